/* project.f */
serial_cpu_pkg.sv
serial_seq_if.sv
serial_dec_if.sv
serial_state.sv
serial_decode.sv
serial_regfile.sv
serial_alu.sv
serial_pc.sv
serial_mem_if.sv
serial_cpu_top.sv
serial_cpu_tb.sv

/* serial_alu.sv */
`timescale 1ns/10ps

module serial_alu (
   input  logic                  clk,
   input  logic                  i_rst,
   serial_seq_if.user            seq,
   serial_dec_if.user            dec,
   input  logic                  i_rs1_bit,
   input  logic                  i_rs2_bit,
   output logic                  o_rd_bit,
   output logic                  o_eq_flag,
   output serial_cpu_pkg::word_t o_buf_adr
);

   serial_cpu_pkg::word_t buf_q;
   logic                  in_exec;
   logic                  sub;
   logic                  op_b;
   logic                  b_inv;
   logic                  carry_in;
   logic                  carry_q;
   logic                  sum;
   logic                  res_bit;
   logic                  eq_q;

   assign in_exec = seq.cnt_en && (seq.phase == serial_cpu_pkg::EXEC);
   assign sub     = dec.alu_op == serial_cpu_pkg::ALU_SUB;
   assign op_b    = dec.op_b_imm ? dec.imm_bit : i_rs2_bit;
   assign b_inv   = op_b ^ sub;

   // Subtract adds the inverted operand plus one
   assign carry_in = (seq.cnt == '0) ? sub : carry_q;
   assign sum      = i_rs1_bit ^ b_inv ^ carry_in;

   always_comb begin
      case (dec.alu_op)
         serial_cpu_pkg::ALU_AND: res_bit = i_rs1_bit & op_b;
         serial_cpu_pkg::ALU_OR:  res_bit = i_rs1_bit | op_b;
         serial_cpu_pkg::ALU_XOR: res_bit = i_rs1_bit ^ op_b;
         default:                 res_bit = sum;
      endcase
   end

   assign o_rd_bit = (dec.op == serial_cpu_pkg::OP_LUI) ? dec.imm_bit : res_bit;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b1;
      end else if (in_exec) begin
         carry_q <= (i_rs1_bit & b_inv) | (i_rs1_bit & carry_in) | (b_inv & carry_in);
         eq_q    <= (i_rs1_bit == op_b) && ((seq.cnt == '0) || eq_q);
      end
   end

   // rs1 plus offset collects here as the data address
   always_ff @(posedge clk) begin
      if (in_exec) begin
         buf_q <= {sum, buf_q[31:1]};
      end
   end

   assign o_eq_flag = eq_q;
   assign o_buf_adr = buf_q;

endmodule

/* serial_cpu_pkg.sv */
package serial_cpu_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [4:0]  bit_cnt_t;

   // Sequencer phases of one instruction
   typedef enum logic [2:0] {
      FETCH,
      DECODE,
      EXEC,
      MEM,
      LOAD,
      PC_UPD
   } phase_e;

   typedef enum logic [2:0] {
      OP_ALU,
      OP_ALUI,
      OP_LUI,
      OP_LOAD,
      OP_STORE,
      OP_BRANCH,
      OP_JAL,
      OP_NOP
   } op_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

endpackage

/* serial_cpu_tb.sv */
`timescale 1ns/10ps

module serial_cpu_tb;

   localparam serial_cpu_pkg::word_t RESET_PC = 32'h0000_0040;
   localparam int BODY = 100;
   localparam int N_TESTS = 3;
   localparam int PROG_LEN = 62 + BODY + 33;
   // Fetch 5, decode 1, exec 32, mem 5, load 32, PC update 32, plus margin
   localparam int CYC_PER_INSTR = 110;

   logic                  clk;
   logic                  i_rst;
   serial_cpu_pkg::word_t o_ibus_adr;
   logic                  o_ibus_cyc;
   serial_cpu_pkg::word_t i_ibus_rdt;
   logic                  i_ibus_ack;
   serial_cpu_pkg::word_t o_dbus_adr;
   serial_cpu_pkg::word_t o_dbus_dat;
   logic [3:0]            o_dbus_sel;
   logic                  o_dbus_we;
   logic                  o_dbus_cyc;
   serial_cpu_pkg::word_t i_dbus_rdt;
   logic                  i_dbus_ack;

   serial_cpu_pkg::word_t rom [256];
   serial_cpu_pkg::word_t dram [serial_cpu_pkg::word_t];
   serial_cpu_pkg::word_t m_ram [serial_cpu_pkg::word_t];
   serial_cpu_pkg::word_t m_regs [32];
   serial_cpu_pkg::word_t m_pc;
   serial_cpu_pkg::word_t halt_pc;

   logic                  pend_acc;
   logic                  pend_we;
   serial_cpu_pkg::word_t pend_adr;
   serial_cpu_pkg::word_t pend_dat;
   logic                  running;
   logic                  prog_done;
   string                 test_name;
   int                    errors;
   int                    checks;
   int                    ib_wait;
   int                    db_wait;

   serial_cpu_top #(
      .RESET_PC (RESET_PC)
   ) i_dut (
      .clk        (clk),
      .i_rst      (i_rst),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_sel (o_dbus_sel),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack)
   );

   always #5 clk = ~clk;

   function automatic serial_cpu_pkg::word_t r_type(input logic [6:0] f7,
         input serial_cpu_pkg::reg_addr_t rs2, input serial_cpu_pkg::reg_addr_t rs1,
         input logic [2:0] f3, input serial_cpu_pkg::reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic serial_cpu_pkg::word_t i_type(input serial_cpu_pkg::word_t imm,
         input serial_cpu_pkg::reg_addr_t rs1, input logic [2:0] f3,
         input serial_cpu_pkg::reg_addr_t rd, input logic [6:0] opc);
      return {imm[11:0], rs1, f3, rd, opc};
   endfunction

   function automatic serial_cpu_pkg::word_t s_type(input serial_cpu_pkg::word_t imm,
         input serial_cpu_pkg::reg_addr_t rs2, input serial_cpu_pkg::reg_addr_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic serial_cpu_pkg::word_t b_type(input serial_cpu_pkg::word_t imm,
         input serial_cpu_pkg::reg_addr_t rs2, input serial_cpu_pkg::reg_addr_t rs1,
         input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic serial_cpu_pkg::word_t u_type(input serial_cpu_pkg::word_t imm,
         input serial_cpu_pkg::reg_addr_t rd);
      return {imm[31:12], rd, 7'b0110111};
   endfunction

   function automatic serial_cpu_pkg::word_t j_type(input serial_cpu_pkg::word_t imm,
         input serial_cpu_pkg::reg_addr_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   function automatic serial_cpu_pkg::reg_addr_t pick_reg();
      serial_cpu_pkg::word_t r;
      r = $urandom;
      return r[4:0];
   endfunction

   // Unwritten RAM words read back a value tied to their address
   function automatic serial_cpu_pkg::word_t ram_fill(input serial_cpu_pkg::word_t a);
      return {a[15:0], a[31:16]} ^ 32'h5bd1_e995;
   endfunction

   // Architectural model that executes the instruction at m_pc
   function automatic void step_model(output logic acc, output logic we,
         output serial_cpu_pkg::word_t adr, output serial_cpu_pkg::word_t dat);
      serial_cpu_pkg::word_t ins;
      serial_cpu_pkg::word_t a;
      serial_cpu_pkg::word_t b;
      serial_cpu_pkg::word_t ea;
      serial_cpu_pkg::word_t res;
      serial_cpu_pkg::word_t npc;
      logic                  wr;
      ins = rom[m_pc[9:2]];
      a   = m_regs[ins[19:15]];
      b   = m_regs[ins[24:20]];
      npc = m_pc + 32'd4;
      wr  = 1'b0;
      res = '0;
      acc = 1'b0;
      we  = 1'b0;
      adr = '0;
      dat = '0;
      case (ins[6:0])
         7'b0010011: begin
            res = a + {{20{ins[31]}}, ins[31:20]};
            wr  = 1'b1;
         end
         7'b0110011: begin
            wr = 1'b1;
            case (ins[14:12])
               3'b000:  res = ins[30] ? a - b : a + b;
               3'b100:  res = a ^ b;
               3'b110:  res = a | b;
               default: res = a & b;
            endcase
         end
         7'b0110111: begin
            res = {ins[31:12], 12'b0};
            wr  = 1'b1;
         end
         7'b0000011: begin
            ea  = a + {{20{ins[31]}}, ins[31:20]};
            adr = {ea[31:2], 2'b00};
            acc = 1'b1;
            res = m_ram.exists(adr) ? m_ram[adr] : ram_fill(adr);
            wr  = 1'b1;
         end
         7'b0100011: begin
            ea  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            adr = {ea[31:2], 2'b00};
            acc = 1'b1;
            we  = 1'b1;
            dat = b;
            m_ram[adr] = b;
         end
         7'b1100011: begin
            // funct3 bit 0 distinguishes BNE from BEQ
            if ((a == b) != ins[12]) begin
               npc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
         end
         7'b1101111: begin
            res = m_pc + 32'd4;
            wr  = 1'b1;
            npc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         default: ;
      endcase
      if (wr && (ins[11:7] != 5'd0)) begin
         m_regs[ins[11:7]] = res;
      end
      m_pc = npc;
   endfunction

   task automatic check_word(input string what, input serial_cpu_pkg::word_t exp,
         input serial_cpu_pkg::word_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Error: %s: %s expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   // Register init, random body with forward-only branches, register dump, halt loop
   task automatic build_program(input int lo, input int hi);
      int                        idx;
      int                        last;
      int                        skip;
      int                        k;
      serial_cpu_pkg::word_t     w;
      serial_cpu_pkg::word_t     imm;
      serial_cpu_pkg::reg_addr_t rd;
      serial_cpu_pkg::reg_addr_t rs1;
      serial_cpu_pkg::reg_addr_t rs2;
      for (int i = 0; i < 256; i++) begin
         rom[i] = j_type('0, '0);
      end
      idx = RESET_PC[9:2];
      for (int r = 1; r < 32; r++) begin
         rd = r[4:0];
         rom[idx]     = u_type($urandom, rd);
         rom[idx + 1] = i_type($urandom, rd, 3'b000, rd, 7'b0010011);
         idx += 2;
      end
      last = idx + BODY;
      while (idx < last) begin
         w    = $urandom;
         rd   = pick_reg();
         rs1  = pick_reg();
         rs2  = pick_reg();
         k    = lo + $urandom % (hi - lo + 1);
         skip = 1 + $urandom % 4;
         if (idx + skip > last) begin
            skip = last - idx;
         end
         case (k)
            0: rom[idx] = i_type(w, rs1, 3'b000, rd, 7'b0010011);
            1: rom[idx] = r_type(7'b0000000, rs2, rs1, 3'b000, rd);
            2: rom[idx] = r_type(7'b0100000, rs2, rs1, 3'b000, rd);
            3: rom[idx] = r_type(7'b0000000, rs2, rs1, 3'b111, rd);
            4: rom[idx] = r_type(7'b0000000, rs2, rs1, 3'b110, rd);
            5: rom[idx] = r_type(7'b0000000, rs2, rs1, 3'b100, rd);
            6: rom[idx] = u_type(w, rd);
            7, 8: begin
               // Half the accesses use x0 as base so loads hit earlier stores
               if (w[31]) begin
                  rs1 = '0;
                  imm = {24'b0, w[7:2], 2'b00};
               end else begin
                  imm = w;
               end
               rom[idx] = (k == 7) ? i_type(imm, rs1, 3'b010, rd, 7'b0000011) :
                                     s_type(imm, rs2, rs1);
            end
            9, 10: begin
               if (w[0]) begin
                  rs2 = rs1;
               end
               rom[idx] = b_type(skip * 4, rs2, rs1, (k == 10) ? 3'b001 : 3'b000);
            end
            default: rom[idx] = j_type(skip * 4, rd);
         endcase
         idx++;
      end
      for (int r = 0; r < 32; r++) begin
         rs2 = r[4:0];
         rom[idx] = s_type(32'h600 + 4 * r, rs2, '0);
         idx++;
      end
      rom[idx] = j_type('0, '0);
      halt_pc  = idx * 4;
   endtask

   task automatic run_test(input string name, input int lo, input int hi);
      test_name = name;
      build_program(lo, hi);
      @(negedge clk);
      i_rst     = 1'b1;
      running   = 1'b0;
      prog_done = 1'b0;
      pend_acc  = 1'b0;
      m_pc      = RESET_PC;
      // Model registers start cleared so x0 reads zero
      for (int r = 0; r < 32; r++) begin
         m_regs[r] = '0;
      end
      repeat (16) @(negedge clk);
      check_word("data request in reset", 32'd0, {31'b0, o_dbus_cyc});
      i_rst   = 1'b0;
      running = 1'b1;
      @(posedge clk);
      @(posedge clk);
      check_word("fetch request after reset", 32'd1, {31'b0, o_ibus_cyc});
      check_word("first fetch address", RESET_PC, o_ibus_adr);
      check_word("data request after reset", 32'd0, {31'b0, o_dbus_cyc});
      wait (prog_done);
   endtask

   // Instruction ROM with a random ack delay
   always @(negedge clk) begin
      if (i_ibus_ack) begin
         i_ibus_ack = 1'b0;
         ib_wait    = -1;
      end else if (o_ibus_cyc) begin
         if (ib_wait < 0) begin
            ib_wait = $urandom % 4;
         end
         if (ib_wait == 0) begin
            i_ibus_ack = 1'b1;
            i_ibus_rdt = rom[o_ibus_adr[9:2]];
         end else begin
            ib_wait--;
         end
      end
   end

   // Data RAM that writes all four lanes together
   always @(negedge clk) begin
      if (i_dbus_ack) begin
         i_dbus_ack = 1'b0;
         db_wait    = -1;
      end else if (o_dbus_cyc) begin
         if (db_wait < 0) begin
            db_wait = $urandom % 4;
         end
         if (db_wait == 0) begin
            i_dbus_ack = 1'b1;
            if (o_dbus_we) begin
               dram[o_dbus_adr] = o_dbus_dat;
            end else begin
               i_dbus_rdt = dram.exists(o_dbus_adr) ? dram[o_dbus_adr] : ram_fill(o_dbus_adr);
            end
         end else begin
            db_wait--;
         end
      end
   end

   // Compares every bus handshake with the model
   always @(posedge clk) begin
      if (running && !prog_done) begin
         if (o_dbus_cyc && i_dbus_ack) begin
            if (!pend_acc) begin
               errors++;
               $display("Error in %s: data bus access with no load or store pending", test_name);
            end else begin
               check_word("data address", pend_adr, o_dbus_adr);
               check_word("write enable", {31'b0, pend_we}, {31'b0, o_dbus_we});
               check_word("byte select", 32'hf, {28'b0, o_dbus_sel});
               if (pend_we) begin
                  check_word("store data", pend_dat, o_dbus_dat);
               end
            end
            pend_acc = 1'b0;
         end
         if (o_ibus_cyc && i_ibus_ack) begin
            if (pend_acc) begin
               errors++;
               $display("Error in %s: load or store at %h never reached the data bus",
                        test_name, pend_adr);
               pend_acc = 1'b0;
            end
            check_word("fetch address", m_pc, o_ibus_adr);
            if ((o_ibus_adr != m_pc) || (m_pc == halt_pc)) begin
               prog_done = 1'b1;
            end else begin
               step_model(pend_acc, pend_we, pend_adr, pend_dat);
            end
         end
      end
   end

   initial begin
      #(N_TESTS * (PROG_LEN * CYC_PER_INSTR + 40) * 10);
      $display("Timeout: a program did not reach its final instruction in time");
      $display("Verification failed");
      $finish;
   end

   initial begin
      void'($urandom(32'hfa9f_f9b5));
      clk        = 1'b0;
      i_rst      = 1'b1;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_dbus_rdt = '0;
      i_dbus_ack = 1'b0;
      ib_wait    = -1;
      db_wait    = -1;
      errors     = 0;
      checks     = 0;
      running    = 1'b0;
      prog_done  = 1'b0;
      pend_acc   = 1'b0;
      run_test("alu_ops", 0, 6);
      run_test("load_store_branch", 7, 11);
      run_test("full_mix", 0, 11);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* serial_cpu_top.sv */
`timescale 1ns/10ps

module serial_cpu_top #(
   parameter serial_cpu_pkg::word_t RESET_PC = '0
) (
   input  logic        clk,
   input  logic        i_rst,
   output logic [31:0] o_ibus_adr,
   output logic        o_ibus_cyc,
   input  logic [31:0] i_ibus_rdt,
   input  logic        i_ibus_ack,
   output logic [31:0] o_dbus_adr,
   output logic [31:0] o_dbus_dat,
   output logic [3:0]  o_dbus_sel,
   output logic        o_dbus_we,
   output logic        o_dbus_cyc,
   input  logic [31:0] i_dbus_rdt,
   input  logic        i_dbus_ack
);

   serial_seq_if seq_bus ();
   serial_dec_if dec_bus ();

   logic                  rs1_bit;
   logic                  rs2_bit;
   logic                  alu_rd_bit;
   logic                  mem_rd_bit;
   logic                  link_bit;
   logic                  rd_bit;
   logic                  alu_sel;
   logic                  eq_flag;
   serial_cpu_pkg::word_t buf_addr;

   serial_state state (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .seq        (seq_bus.seq),
      .dec        (dec_bus.user),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc)
   );

   serial_decode decode (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_eq_flag  (eq_flag),
      .seq        (seq_bus.user),
      .dec        (dec_bus.dec)
   );

   serial_regfile regfile (
      .clk       (clk),
      .seq       (seq_bus.user),
      .dec       (dec_bus.user),
      .i_rd_bit  (rd_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   serial_alu alu (
      .clk       (clk),
      .i_rst     (i_rst),
      .seq       (seq_bus.user),
      .dec       (dec_bus.user),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .o_rd_bit  (alu_rd_bit),
      .o_eq_flag (eq_flag),
      .o_buf_adr (buf_addr)
   );

   serial_pc #(
      .RESET_PC (RESET_PC)
   ) pc (
      .clk        (clk),
      .i_rst      (i_rst),
      .seq        (seq_bus.user),
      .dec        (dec_bus.user),
      .o_link_bit (link_bit),
      .o_ibus_adr (o_ibus_adr)
   );

   serial_mem_if mem_if (
      .clk        (clk),
      .seq        (seq_bus.user),
      .dec        (dec_bus.user),
      .i_rs2_bit  (rs2_bit),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_rd_bit   (mem_rd_bit),
      .o_dbus_dat (o_dbus_dat)
   );

   // Only one source is live per phase, so they are simply ORed
   assign alu_sel = dec_bus.op inside {serial_cpu_pkg::OP_ALU, serial_cpu_pkg::OP_ALUI,
                                       serial_cpu_pkg::OP_LUI};

   assign rd_bit = ((dec_bus.op == serial_cpu_pkg::OP_JAL) && link_bit) |
                   (alu_sel && alu_rd_bit) |
                   mem_rd_bit;

   assign o_dbus_adr = {buf_addr[31:2], 2'b00};
   assign o_dbus_we  = dec_bus.op == serial_cpu_pkg::OP_STORE;
   assign o_dbus_sel = 4'b1111;

endmodule

/* serial_dec_if.sv */
`timescale 1ns/10ps

interface serial_dec_if;

   serial_cpu_pkg::op_e       op;
   serial_cpu_pkg::alu_op_e   alu_op;
   serial_cpu_pkg::reg_addr_t rs1_addr;
   serial_cpu_pkg::reg_addr_t rs2_addr;
   serial_cpu_pkg::reg_addr_t rd_addr;
   logic                      rd_en;
   logic                      imm_bit;
   logic                      op_b_imm;
   logic                      take_branch;

   modport dec (
      output op, alu_op, rs1_addr, rs2_addr, rd_addr,
      output rd_en, imm_bit, op_b_imm, take_branch
   );

   modport user (
      input op, alu_op, rs1_addr, rs2_addr, rd_addr,
      input rd_en, imm_bit, op_b_imm, take_branch
   );

endinterface

/* serial_decode.sv */
`timescale 1ns/10ps

module serial_decode (
   input  logic                  clk,
   input  logic                  i_rst,
   input  serial_cpu_pkg::word_t i_ibus_rdt,
   input  logic                  i_ibus_ack,
   input  logic                  i_eq_flag,
   serial_seq_if.user            seq,
   serial_dec_if.dec             dec
);

   serial_cpu_pkg::word_t   ir_q;
   serial_cpu_pkg::word_t   imm;
   serial_cpu_pkg::op_e     op;
   serial_cpu_pkg::alu_op_e alu_op;
   logic [2:0]              funct3;

   assign funct3 = ir_q[14:12];

   always_ff @(posedge clk) begin
      if (i_rst) begin
         ir_q <= '0;
      end else if ((seq.phase == serial_cpu_pkg::FETCH) && i_ibus_ack) begin
         ir_q <= i_ibus_rdt;
      end
   end

   // Anything outside the subset falls through as a no-op
   always_comb begin
      op     = serial_cpu_pkg::OP_NOP;
      alu_op = serial_cpu_pkg::ALU_ADD;
      case (ir_q[6:0])
         7'b0110011, 7'b0010011: begin
            op = ir_q[5] ? serial_cpu_pkg::OP_ALU : serial_cpu_pkg::OP_ALUI;
            case (funct3)
               3'b000: begin
                  if (ir_q[5] && ir_q[30]) begin
                     alu_op = serial_cpu_pkg::ALU_SUB;
                  end
               end
               3'b100: alu_op = serial_cpu_pkg::ALU_XOR;
               3'b110: alu_op = serial_cpu_pkg::ALU_OR;
               3'b111: alu_op = serial_cpu_pkg::ALU_AND;
               default: op = serial_cpu_pkg::OP_NOP;
            endcase
         end
         7'b0110111: op = serial_cpu_pkg::OP_LUI;
         7'b0000011: op = (funct3 == 3'b010) ? serial_cpu_pkg::OP_LOAD : serial_cpu_pkg::OP_NOP;
         7'b0100011: op = (funct3 == 3'b010) ? serial_cpu_pkg::OP_STORE : serial_cpu_pkg::OP_NOP;
         7'b1100011: op = (funct3[2:1] == 2'b00) ? serial_cpu_pkg::OP_BRANCH :
                          serial_cpu_pkg::OP_NOP;
         7'b1101111: op = serial_cpu_pkg::OP_JAL;
         default: ;
      endcase
   end

   always_comb begin
      case (op)
         serial_cpu_pkg::OP_STORE:  imm = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
         serial_cpu_pkg::OP_BRANCH: imm = {{20{ir_q[31]}}, ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
         serial_cpu_pkg::OP_LUI:    imm = {ir_q[31:12], 12'b0};
         serial_cpu_pkg::OP_JAL:    imm = {{12{ir_q[31]}}, ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};
         default:                   imm = {{21{ir_q[31]}}, ir_q[30:20]};
      endcase
   end

   assign dec.op       = op;
   assign dec.alu_op   = alu_op;
   assign dec.rs1_addr = ir_q[19:15];
   assign dec.rs2_addr = ir_q[24:20];
   assign dec.rd_addr  = ir_q[11:7];
   assign dec.imm_bit  = imm[seq.cnt];
   assign dec.rd_en    = op inside {serial_cpu_pkg::OP_ALU, serial_cpu_pkg::OP_ALUI,
                                    serial_cpu_pkg::OP_LUI, serial_cpu_pkg::OP_LOAD,
                                    serial_cpu_pkg::OP_JAL};
   assign dec.op_b_imm = op inside {serial_cpu_pkg::OP_ALUI, serial_cpu_pkg::OP_LOAD,
                                    serial_cpu_pkg::OP_STORE};

   // funct3[0] flips BEQ into BNE
   assign dec.take_branch = (op == serial_cpu_pkg::OP_JAL) ||
                            ((op == serial_cpu_pkg::OP_BRANCH) && (funct3[0] ^ i_eq_flag));

endmodule

/* serial_mem_if.sv */
`timescale 1ns/10ps

module serial_mem_if (
   input  logic                  clk,
   serial_seq_if.user            seq,
   serial_dec_if.user            dec,
   input  logic                  i_rs2_bit,
   input  serial_cpu_pkg::word_t i_dbus_rdt,
   input  logic                  i_dbus_ack,
   output logic                  o_rd_bit,
   output serial_cpu_pkg::word_t o_dbus_dat
);

   serial_cpu_pkg::word_t dat_q;
   logic                  store_shift;
   logic                  load_capture;
   logic                  load_shift;

   assign store_shift = seq.cnt_en && (seq.phase == serial_cpu_pkg::EXEC) &&
                        (dec.op == serial_cpu_pkg::OP_STORE);

   assign load_capture = (seq.phase == serial_cpu_pkg::MEM) && i_dbus_ack &&
                         (dec.op == serial_cpu_pkg::OP_LOAD);

   assign load_shift = seq.cnt_en && (seq.phase == serial_cpu_pkg::LOAD);

   // Store data and load data share one register, lsb first
   always_ff @(posedge clk) begin
      if (load_capture) begin
         dat_q <= i_dbus_rdt;
      end else if (store_shift) begin
         dat_q <= {i_rs2_bit, dat_q[31:1]};
      end else if (load_shift) begin
         dat_q <= {1'b0, dat_q[31:1]};
      end
   end

   assign o_rd_bit   = load_shift && dat_q[0];
   assign o_dbus_dat = dat_q;

endmodule

/* serial_pc.sv */
`timescale 1ns/10ps

module serial_pc #(
   parameter serial_cpu_pkg::word_t RESET_PC = '0
) (
   input  logic                  clk,
   input  logic                  i_rst,
   serial_seq_if.user            seq,
   serial_dec_if.user            dec,
   output logic                  o_link_bit,
   output serial_cpu_pkg::word_t o_ibus_adr
);

   serial_cpu_pkg::word_t pc_q;
   serial_cpu_pkg::word_t npc_q;
   logic                  upd;
   logic                  pc_bit;
   logic                  off_bit;
   logic                  carry_in;
   logic                  carry_q;
   logic                  sum;

   assign upd    = seq.cnt_en && (seq.phase == serial_cpu_pkg::PC_UPD);
   assign pc_bit = pc_q[seq.cnt];

   // Immediate on a taken branch or JAL, otherwise the constant 4
   assign off_bit  = (upd && dec.take_branch) ? dec.imm_bit : (seq.cnt == 5'd2);
   assign carry_in = (seq.cnt != '0) && carry_q;
   assign sum      = pc_bit ^ off_bit ^ carry_in;

   // PC+4 while in EXEC
   assign o_link_bit = sum;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         pc_q    <= RESET_PC;
         carry_q <= 1'b0;
      end else begin
         if (seq.cnt_en) begin
            carry_q <= (pc_bit & off_bit) | (pc_bit & carry_in) | (off_bit & carry_in);
         end
         if (upd && seq.cnt_done) begin
            pc_q <= {sum, npc_q[31:1]};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (upd) begin
         npc_q <= {sum, npc_q[31:1]};
      end
   end

   assign o_ibus_adr = pc_q;

endmodule

/* serial_regfile.sv */
`timescale 1ns/10ps

module serial_regfile (
   input  logic       clk,
   serial_seq_if.user seq,
   serial_dec_if.user dec,
   input  logic       i_rd_bit,
   output logic       o_rs1_bit,
   output logic       o_rs2_bit
);

   serial_cpu_pkg::word_t regs [32];
   logic                  wr_phase;
   logic                  wr_en;

   // Loads write rd in LOAD, every other writer during EXEC
   assign wr_phase = (seq.phase == serial_cpu_pkg::LOAD) ||
                     ((seq.phase == serial_cpu_pkg::EXEC) &&
                      (dec.op != serial_cpu_pkg::OP_LOAD));

   assign wr_en = wr_phase && seq.cnt_en && dec.rd_en && (dec.rd_addr != '0);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         regs[dec.rd_addr][seq.cnt] <= i_rd_bit;
      end
   end

   // x0 is never written and always reads zero
   assign o_rs1_bit = (dec.rs1_addr != '0) && regs[dec.rs1_addr][seq.cnt];
   assign o_rs2_bit = (dec.rs2_addr != '0) && regs[dec.rs2_addr][seq.cnt];

endmodule

/* serial_seq_if.sv */
`timescale 1ns/10ps

interface serial_seq_if;

   serial_cpu_pkg::bit_cnt_t cnt;
   logic                     cnt_en;
   logic                     cnt_done;
   serial_cpu_pkg::phase_e   phase;

   modport seq (
      output cnt,
      output cnt_en,
      output cnt_done,
      output phase
   );

   modport user (
      input cnt,
      input cnt_en,
      input cnt_done,
      input phase
   );

endinterface

/* serial_state.sv */
`timescale 1ns/10ps

module serial_state (
   input  logic       clk,
   input  logic       i_rst,
   input  logic       i_ibus_ack,
   input  logic       i_dbus_ack,
   serial_seq_if.seq  seq,
   serial_dec_if.user dec,
   output logic       o_ibus_cyc,
   output logic       o_dbus_cyc
);

   serial_cpu_pkg::phase_e   phase_q;
   serial_cpu_pkg::bit_cnt_t cnt_q;
   logic                     cnt_en;
   logic                     cnt_done;
   logic                     mem_op;

   assign cnt_en = (phase_q == serial_cpu_pkg::EXEC) ||
                   (phase_q == serial_cpu_pkg::LOAD) ||
                   (phase_q == serial_cpu_pkg::PC_UPD);
   assign cnt_done = cnt_en && (cnt_q == 5'd31);
   assign mem_op = (dec.op == serial_cpu_pkg::OP_LOAD) || (dec.op == serial_cpu_pkg::OP_STORE);

   assign seq.cnt      = cnt_q;
   assign seq.cnt_en   = cnt_en;
   assign seq.cnt_done = cnt_done;
   assign seq.phase    = phase_q;

   // Wraps back to zero at the end of each serial phase
   always_ff @(posedge clk) begin
      if (i_rst) begin
         cnt_q <= '0;
      end else if (cnt_en) begin
         cnt_q <= cnt_q + 5'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         phase_q    <= serial_cpu_pkg::FETCH;
         o_ibus_cyc <= 1'b0;
         o_dbus_cyc <= 1'b0;
      end else begin
         case (phase_q)
            serial_cpu_pkg::FETCH: begin
               if (o_ibus_cyc && i_ibus_ack) begin
                  o_ibus_cyc <= 1'b0;
                  phase_q    <= serial_cpu_pkg::DECODE;
               end else begin
                  // First request after reset
                  o_ibus_cyc <= 1'b1;
               end
            end
            serial_cpu_pkg::DECODE: begin
               phase_q <= serial_cpu_pkg::EXEC;
            end
            serial_cpu_pkg::EXEC: begin
               if (cnt_done && mem_op) begin
                  phase_q    <= serial_cpu_pkg::MEM;
                  o_dbus_cyc <= 1'b1;
               end else if (cnt_done) begin
                  phase_q <= serial_cpu_pkg::PC_UPD;
               end
            end
            serial_cpu_pkg::MEM: begin
               if (o_dbus_cyc && i_dbus_ack) begin
                  o_dbus_cyc <= 1'b0;
                  phase_q    <= (dec.op == serial_cpu_pkg::OP_LOAD) ?
                                serial_cpu_pkg::LOAD : serial_cpu_pkg::PC_UPD;
               end
            end
            serial_cpu_pkg::LOAD: begin
               if (cnt_done) begin
                  phase_q <= serial_cpu_pkg::PC_UPD;
               end
            end
            default: begin
               // New PC is loaded on this same edge
               if (cnt_done) begin
                  phase_q    <= serial_cpu_pkg::FETCH;
                  o_ibus_cyc <= 1'b1;
               end
            end
         endcase
      end
   end

endmodule
